//--- design/ctrl_macros.svh
////////////////////////////////////////////////////////////////////////////
// Shared widths of the pipeline controller
// Exception cause codes reported for traps taken from WB
// Cause codes of the LSU bus error NMIs
////////////////////////////////////////////////////////////////////////////

`ifndef CTRL_MACROS_SVH
`define CTRL_MACROS_SVH

// Interrupt id and cause field widths
`define CTRL_IRQ_ID_W 5
`define CTRL_CAUSE_W  8

// Synchronous exception codes
// Instruction fault and bus fault share one code
`define CTRL_EXC_INSTR_FAULT     8'd1
`define CTRL_EXC_INSTR_BUS_FAULT 8'd1
`define CTRL_EXC_ILLEGAL         8'd2
`define CTRL_EXC_BREAKPOINT      8'd3
`define CTRL_EXC_LOAD_FAULT      8'd5
`define CTRL_EXC_STORE_FAULT     8'd7
`define CTRL_EXC_ECALL_M         8'd11

// NMI codes, kept clear of the interrupt id range
`define CTRL_NMI_LOAD_FAULT  8'd128
`define CTRL_NMI_STORE_FAULT 8'd129

`endif

//--- design/ctrl_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Controller package
// FSM state, PC mux selects, PC save select and MPU status types
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package ctrl_pkg;

  // Main controller FSM states
  typedef enum logic [1:0] {
    RESET      = 2'd0,
    BOOT_SET   = 2'd1,
    FUNCTIONAL = 2'd2,
    SLEEP      = 2'd3
  } ctrl_state_e;

  // Source of the next fetch PC
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,
    PC_BRANCH    = 3'd2,
    PC_MRET      = 3'd3,
    PC_EXCEPTION = 3'd4
  } pc_mux_e;

  // Handler base used when pc_mux is PC_EXCEPTION
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'd0,
    EXC_PC_IRQ       = 2'd1,
    EXC_PC_NMI       = 2'd2
  } exc_pc_mux_e;

  // Stage whose PC is written to the exception PC register
  typedef enum logic [1:0] {
    SAVE_IF = 2'd0,
    SAVE_ID = 2'd1,
    SAVE_EX = 2'd2,
    SAVE_WB = 2'd3
  } save_sel_e;

  // MPU check result of the instruction in WB
  typedef enum logic [1:0] {
    MPU_OK       = 2'd0,
    MPU_RE_FAULT = 2'd1,
    MPU_WR_FAULT = 2'd2
  } mpu_status_e;

endpackage

`default_nettype wire

//--- design/wb_event_if.sv
////////////////////////////////////////////////////////////////////////////
// Decoded WB-stage events
// Driven by the WB decoder, read by the FSM and the trap logic
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ctrl_macros.svh"

interface wb_event_if;

  // All fields are combinational and valid every cycle
  logic                     exception;
  logic [`CTRL_CAUSE_W-1:0] cause;
  logic                     wfi;
  logic                     mret;
  // Valid load/store sitting in WB
  logic                     lsu_busy;

  modport decoder (output exception, cause, wfi, mret, lsu_busy);
  modport fsm     (input  exception, cause, wfi, mret);
  modport trap    (input  lsu_busy);

endinterface

`default_nettype wire

//--- design/wb_event_decode.sv
////////////////////////////////////////////////////////////////////////////
// WB-stage event decoder
// Qualifies WB flags, flags exceptions and picks the cause by priority
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ctrl_macros.svh"

module wb_event_decode (
  input  logic                  wb_instr_valid_i,
  input  logic                  wb_instr_fault_i,
  input  logic                  wb_instr_bus_err_i,
  input  logic                  wb_illegal_i,
  input  logic                  wb_ecall_i,
  input  logic                  wb_ebreak_i,
  input  ctrl_pkg::mpu_status_e wb_mpu_status_i,
  input  logic                  wb_wfi_i,
  input  logic                  wb_mret_i,
  input  logic                  wb_lsu_i,
  wb_event_if.decoder           ev
);
  import ctrl_pkg::*;

  // Qualified fault sources
  logic instr_fault;
  logic bus_fault;
  logic illegal;
  logic ecall;
  logic ebreak;
  logic mpu_fault;

  assign instr_fault = wb_instr_valid_i && wb_instr_fault_i;
  assign bus_fault   = wb_instr_valid_i && wb_instr_bus_err_i;
  assign illegal     = wb_instr_valid_i && wb_illegal_i;
  assign ecall       = wb_instr_valid_i && wb_ecall_i;
  assign ebreak      = wb_instr_valid_i && wb_ebreak_i;
  // Data side MPU check, any non-OK status traps
  assign mpu_fault   = wb_instr_valid_i && (wb_mpu_status_i != MPU_OK);

  assign ev.exception = instr_fault || bus_fault || illegal || ecall || ebreak || mpu_fault;

  // Cause priority, highest first
  always_comb begin
    ev.cause = '0;
    if (instr_fault) begin
      ev.cause = `CTRL_EXC_INSTR_FAULT;
    end else if (bus_fault) begin
      ev.cause = `CTRL_EXC_INSTR_BUS_FAULT;
    end else if (illegal) begin
      ev.cause = `CTRL_EXC_ILLEGAL;
    end else if (ecall) begin
      ev.cause = `CTRL_EXC_ECALL_M;
    end else if (ebreak) begin
      ev.cause = `CTRL_EXC_BREAKPOINT;
    end else if (mpu_fault && (wb_mpu_status_i == MPU_WR_FAULT)) begin
      ev.cause = `CTRL_EXC_STORE_FAULT;
    end else if (mpu_fault) begin
      // Read fault and any unknown status
      ev.cause = `CTRL_EXC_LOAD_FAULT;
    end
  end

  // Special instructions and LSU occupancy
  assign ev.wfi      = wb_instr_valid_i && wb_wfi_i;
  assign ev.mret     = wb_instr_valid_i && wb_mret_i;
  assign ev.lsu_busy = wb_instr_valid_i && wb_lsu_i;

endmodule

`default_nettype wire

//--- design/trap_pending.sv
////////////////////////////////////////////////////////////////////////////
// Trap request logic
// Sticky NMI from LSU bus errors, take and hold-off for NMI and interrupts
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module trap_pending (
  input  logic        clk,
  input  logic        rst_n,
  wb_event_if.trap    ev,
  input  logic        lsu_err_wb_i,
  input  logic        wb_rf_we_i,
  input  logic        irq_req_i,
  input  logic        nmi_taken_i,
  output logic        take_nmi_o,
  output logic        take_irq_o,
  output logic        hold_id_o,
  output logic        nmi_is_store_o,
  output logic        pending_nmi_o
);

  logic nmi_pending_q;
  logic nmi_is_store_q;
  logic nmi_set;
  logic trap_allowed;

  // First error wins, later ones do not overwrite it
  assign nmi_set = lsu_err_wb_i && !nmi_pending_q;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      nmi_pending_q <= 1'b0;
    end else if (nmi_set) begin
      nmi_pending_q <= 1'b1;
    end else if (nmi_taken_i) begin
      // Cleared at the edge ending the taking cycle
      nmi_pending_q <= 1'b0;
    end
  end

  // Store when the faulting access writes no register
  always_ff @(posedge clk) begin
    if (nmi_set) begin
      nmi_is_store_q <= !wb_rf_we_i;
    end
  end

  // A load/store in WB must complete, so no trap may kill it
  assign trap_allowed = !ev.lsu_busy;

  assign take_nmi_o = nmi_pending_q && trap_allowed;
  assign take_irq_o = irq_req_i && trap_allowed;

  // Stall ID to drain WB into an interruptible bubble
  assign hold_id_o = (nmi_pending_q || irq_req_i) && !trap_allowed;

  assign nmi_is_store_o = nmi_is_store_q;
  assign pending_nmi_o  = nmi_pending_q;

endmodule

`default_nettype wire

//--- design/ctrl_fsm.sv
////////////////////////////////////////////////////////////////////////////
// Main pipeline controller FSM
// Boot, trap entry, WB exceptions, WFI sleep, branch and jump redirect
// Branch-taken flag and selection of the PC to save
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ctrl_macros.svh"

module ctrl_fsm (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          fetch_enable_i,
  wb_event_if.fsm                       ev,
  // Trap requests
  input  logic                          take_nmi_i,
  input  logic                          take_irq_i,
  input  logic                          hold_id_i,
  input  logic                          nmi_is_store_i,
  input  logic [`CTRL_IRQ_ID_W-1:0]     irq_id_i,
  input  logic                          irq_wu_i,
  input  logic                          mtvec_vectored_i,
  // Pipeline state
  input  logic                          id_instr_valid_i,
  input  logic                          id_jump_i,
  input  logic                          id_mret_i,
  input  logic                          id_stall_i,
  input  logic                          ex_instr_valid_i,
  input  logic                          ex_branch_taken_i,
  input  logic                          wb_instr_valid_i,
  input  logic                          if_valid_i,
  input  logic                          id_ready_i,
  // Fetch control
  output logic                          instr_req_o,
  output logic                          ctrl_busy_o,
  output logic                          pc_set_o,
  output ctrl_pkg::pc_mux_e             pc_mux_o,
  output ctrl_pkg::exc_pc_mux_e         exc_pc_mux_o,
  output logic [`CTRL_IRQ_ID_W-1:0]     exc_vec_o,
  // Stage control
  output logic                          kill_if_o,
  output logic                          kill_id_o,
  output logic                          kill_ex_o,
  output logic                          kill_wb_o,
  output logic                          halt_if_o,
  output logic                          halt_id_o,
  output logic                          halt_wb_o,
  // Interrupt acknowledge
  output logic                          irq_ack_o,
  output logic [`CTRL_IRQ_ID_W-1:0]     irq_id_o,
  // CSR updates
  output logic                          csr_save_cause_o,
  output logic                          csr_cause_irq_o,
  output logic [`CTRL_CAUSE_W-1:0]      csr_cause_code_o,
  output ctrl_pkg::save_sel_e           csr_save_sel_o,
  output logic                          csr_restore_mret_o,
  output logic                          nmi_taken_o
);
  import ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // Set once a redirect is taken, blocks a second one while held
  logic branch_taken_q;
  logic branch_taken_d;

  logic      branch_taken_ex;
  logic      jump_taken_id;
  save_sel_e oldest_sel;

  // Branch resolved in EX
  assign branch_taken_ex = ex_instr_valid_i && ex_branch_taken_i && !branch_taken_q;

  // Jump or mret in ID, only once its operands are ready
  assign jump_taken_id = id_instr_valid_i && (id_jump_i || id_mret_i) && !id_stall_i &&
                         !branch_taken_q;

  // Oldest valid stage, IF PC is always usable
  always_comb begin
    if (wb_instr_valid_i) begin
      oldest_sel = SAVE_WB;
    end else if (ex_instr_valid_i) begin
      oldest_sel = SAVE_EX;
    end else if (id_instr_valid_i) begin
      oldest_sel = SAVE_ID;
    end else begin
      oldest_sel = SAVE_IF;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d          = state_q;
    branch_taken_d   = branch_taken_q;
    instr_req_o      = 1'b1;
    ctrl_busy_o      = 1'b1;
    pc_set_o         = 1'b0;
    pc_mux_o         = PC_BOOT;
    exc_pc_mux_o     = EXC_PC_EXCEPTION;
    exc_vec_o        = '0;
    kill_if_o        = 1'b0;
    kill_id_o        = 1'b0;
    kill_ex_o        = 1'b0;
    kill_wb_o        = 1'b0;
    halt_if_o        = 1'b0;
    // Regular ID stalls plus trap hold-off
    halt_id_o        = id_stall_i || hold_id_i;
    halt_wb_o        = 1'b0;
    irq_ack_o        = 1'b0;
    irq_id_o         = '0;
    csr_save_cause_o = 1'b0;
    csr_cause_irq_o  = 1'b0;
    csr_cause_code_o = '0;
    csr_save_sel_o   = SAVE_IF;
    nmi_taken_o      = 1'b0;

    unique case (state_q)
      RESET: begin
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end
      // Registered step keeps fetch_enable_i off the PC path
      BOOT_SET: begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
        state_d  = FUNCTIONAL;
      end
      FUNCTIONAL: begin
        if (take_nmi_i || take_irq_i) begin
          // Flush everything, trap to handler
          kill_if_o        = 1'b1;
          kill_id_o        = 1'b1;
          kill_ex_o        = 1'b1;
          kill_wb_o        = 1'b1;
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXCEPTION;
          csr_save_cause_o = 1'b1;
          csr_cause_irq_o  = 1'b1;
          csr_save_sel_o   = oldest_sel;
          if (take_nmi_i) begin
            // NMI beats a simultaneous interrupt
            exc_pc_mux_o     = EXC_PC_NMI;
            csr_cause_code_o = nmi_is_store_i ? `CTRL_NMI_STORE_FAULT : `CTRL_NMI_LOAD_FAULT;
            nmi_taken_o      = 1'b1;
          end else begin
            exc_pc_mux_o     = EXC_PC_IRQ;
            csr_cause_code_o = {{(`CTRL_CAUSE_W - `CTRL_IRQ_ID_W){1'b0}}, irq_id_i};
            irq_ack_o        = 1'b1;
            irq_id_o         = irq_id_i;
            if (mtvec_vectored_i) begin
              exc_vec_o = irq_id_i;
            end
          end
        end else if (ev.exception) begin
          // WB writes are suppressed already, WB itself stays
          kill_if_o        = 1'b1;
          kill_id_o        = 1'b1;
          kill_ex_o        = 1'b1;
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXCEPTION;
          exc_pc_mux_o     = EXC_PC_EXCEPTION;
          csr_save_cause_o = 1'b1;
          csr_cause_code_o = ev.cause;
          csr_save_sel_o   = SAVE_WB;
        end else if (ev.wfi) begin
          // EX may still drain into WB before sleeping
          halt_if_o   = 1'b1;
          halt_id_o   = 1'b1;
          instr_req_o = 1'b0;
          state_d     = SLEEP;
        end else if (branch_taken_ex) begin
          kill_if_o      = 1'b1;
          kill_id_o      = 1'b1;
          pc_set_o       = 1'b1;
          pc_mux_o       = PC_BRANCH;
          branch_taken_d = 1'b1;
        end else if (jump_taken_id) begin
          kill_if_o      = 1'b1;
          pc_set_o       = 1'b1;
          pc_mux_o       = id_mret_i ? PC_MRET : PC_JUMP;
          branch_taken_d = 1'b1;
        end
      end
      SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        // Halting WB stalls the whole pipe
        halt_wb_o   = 1'b1;
        if (irq_wu_i) begin
          ctrl_busy_o = 1'b1;
          state_d     = FUNCTIONAL;
        end
      end
      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase

    // New instruction leaves IF, redirect may be taken again
    if (branch_taken_q && if_valid_i && id_ready_i) begin
      branch_taken_d = 1'b0;
    end
  end

  // mret in WB restores status unless a trap kills it
  assign csr_restore_mret_o = (state_q == FUNCTIONAL) && ev.mret && !kill_wb_o;

  ////////////////////////////////////////////////////////////////////////////
  // State registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q        <= RESET;
      branch_taken_q <= 1'b0;
    end else begin
      state_q        <= state_d;
      branch_taken_q <= branch_taken_d;
    end
  end

endmodule

`default_nettype wire

//--- design/ctrl_top.sv
////////////////////////////////////////////////////////////////////////////
// Pipeline controller top level
// WB decoder, trap request logic and main FSM on plain ports
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ctrl_macros.svh"

module ctrl_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      fetch_enable_i,
  // ID stage
  input  logic                      id_instr_valid_i,
  input  logic                      id_jump_i,
  input  logic                      id_mret_i,
  input  logic                      id_stall_i,
  // EX stage
  input  logic                      ex_instr_valid_i,
  input  logic                      ex_branch_taken_i,
  // WB stage
  input  logic                      wb_instr_valid_i,
  input  logic                      wb_instr_fault_i,
  input  logic                      wb_instr_bus_err_i,
  input  logic                      wb_illegal_i,
  input  logic                      wb_ecall_i,
  input  logic                      wb_ebreak_i,
  input  logic                      wb_wfi_i,
  input  logic                      wb_mret_i,
  input  logic                      wb_lsu_i,
  input  logic                      wb_rf_we_i,
  input  ctrl_pkg::mpu_status_e     wb_mpu_status_i,
  input  logic                      lsu_err_wb_i,
  // Interrupts
  input  logic                      irq_req_i,
  input  logic [`CTRL_IRQ_ID_W-1:0] irq_id_i,
  input  logic                      irq_wu_i,
  input  logic                      mtvec_vectored_i,
  // Pipeline flow
  input  logic                      if_valid_i,
  input  logic                      id_ready_i,
  // Fetch and PC
  output logic                      instr_req_o,
  output logic                      ctrl_busy_o,
  output logic                      pc_set_o,
  output ctrl_pkg::pc_mux_e         pc_mux_o,
  output ctrl_pkg::exc_pc_mux_e     exc_pc_mux_o,
  output logic [`CTRL_IRQ_ID_W-1:0] exc_vec_o,
  // Kills and halts
  output logic                      kill_if_o,
  output logic                      kill_id_o,
  output logic                      kill_ex_o,
  output logic                      kill_wb_o,
  output logic                      halt_if_o,
  output logic                      halt_id_o,
  output logic                      halt_wb_o,
  // Interrupt acknowledge
  output logic                      irq_ack_o,
  output logic [`CTRL_IRQ_ID_W-1:0] irq_id_o,
  // CSR control
  output logic                      csr_save_cause_o,
  output logic                      csr_cause_irq_o,
  output logic [`CTRL_CAUSE_W-1:0]  csr_cause_code_o,
  output ctrl_pkg::save_sel_e       csr_save_sel_o,
  output logic                      csr_restore_mret_o,
  output logic                      pending_nmi_o
);

  // Trap handshake between request logic and FSM
  logic take_nmi;
  logic take_irq;
  logic hold_id;
  logic nmi_is_store;
  logic nmi_taken;

  wb_event_if ev_if ();

  wb_event_decode u_wb_event_decode (
    .wb_instr_valid_i   (wb_instr_valid_i),
    .wb_instr_fault_i   (wb_instr_fault_i),
    .wb_instr_bus_err_i (wb_instr_bus_err_i),
    .wb_illegal_i       (wb_illegal_i),
    .wb_ecall_i         (wb_ecall_i),
    .wb_ebreak_i        (wb_ebreak_i),
    .wb_mpu_status_i    (wb_mpu_status_i),
    .wb_wfi_i           (wb_wfi_i),
    .wb_mret_i          (wb_mret_i),
    .wb_lsu_i           (wb_lsu_i),
    .ev                 (ev_if.decoder)
  );

  trap_pending u_trap_pending (
    .clk            (clk),
    .rst_n          (rst_n),
    .ev             (ev_if.trap),
    .lsu_err_wb_i   (lsu_err_wb_i),
    .wb_rf_we_i     (wb_rf_we_i),
    .irq_req_i      (irq_req_i),
    .nmi_taken_i    (nmi_taken),
    .take_nmi_o     (take_nmi),
    .take_irq_o     (take_irq),
    .hold_id_o      (hold_id),
    .nmi_is_store_o (nmi_is_store),
    .pending_nmi_o  (pending_nmi_o)
  );

  ctrl_fsm u_ctrl_fsm (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_enable_i     (fetch_enable_i),
    .ev                 (ev_if.fsm),
    .take_nmi_i         (take_nmi),
    .take_irq_i         (take_irq),
    .hold_id_i          (hold_id),
    .nmi_is_store_i     (nmi_is_store),
    .irq_id_i           (irq_id_i),
    .irq_wu_i           (irq_wu_i),
    .mtvec_vectored_i   (mtvec_vectored_i),
    .id_instr_valid_i   (id_instr_valid_i),
    .id_jump_i          (id_jump_i),
    .id_mret_i          (id_mret_i),
    .id_stall_i         (id_stall_i),
    .ex_instr_valid_i   (ex_instr_valid_i),
    .ex_branch_taken_i  (ex_branch_taken_i),
    .wb_instr_valid_i   (wb_instr_valid_i),
    .if_valid_i         (if_valid_i),
    .id_ready_i         (id_ready_i),
    .instr_req_o        (instr_req_o),
    .ctrl_busy_o        (ctrl_busy_o),
    .pc_set_o           (pc_set_o),
    .pc_mux_o           (pc_mux_o),
    .exc_pc_mux_o       (exc_pc_mux_o),
    .exc_vec_o          (exc_vec_o),
    .kill_if_o          (kill_if_o),
    .kill_id_o          (kill_id_o),
    .kill_ex_o          (kill_ex_o),
    .kill_wb_o          (kill_wb_o),
    .halt_if_o          (halt_if_o),
    .halt_id_o          (halt_id_o),
    .halt_wb_o          (halt_wb_o),
    .irq_ack_o          (irq_ack_o),
    .irq_id_o           (irq_id_o),
    .csr_save_cause_o   (csr_save_cause_o),
    .csr_cause_irq_o    (csr_cause_irq_o),
    .csr_cause_code_o   (csr_cause_code_o),
    .csr_save_sel_o     (csr_save_sel_o),
    .csr_restore_mret_o (csr_restore_mret_o),
    .nmi_taken_o        (nmi_taken)
  );

endmodule

`default_nettype wire

//--- verif/ctrl_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench of the pipeline controller
// Reads per-cycle vectors, drives on the falling edge, checks all outputs
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ctrl_macros.svh"

module ctrl_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import ctrl_pkg::*;

  localparam int VEC_W      = 71;
  localparam int MAX_VEC    = 256;
  localparam int WAIT_LIMIT = 20;

  logic [VEC_W-1:0] vec_mem [0:MAX_VEC-1];
  logic [VEC_W-1:0] vec;

  logic clk;
  logic rst_n;
  logic fetch_enable_i;
  logic id_instr_valid_i;
  logic id_jump_i;
  logic id_mret_i;
  logic id_stall_i;
  logic ex_instr_valid_i;
  logic ex_branch_taken_i;
  logic wb_instr_valid_i;
  logic wb_instr_fault_i;
  logic wb_instr_bus_err_i;
  logic wb_illegal_i;
  logic wb_ecall_i;
  logic wb_ebreak_i;
  logic wb_wfi_i;
  logic wb_mret_i;
  logic wb_lsu_i;
  logic wb_rf_we_i;
  mpu_status_e wb_mpu_status_i;
  logic lsu_err_wb_i;
  logic irq_req_i;
  logic [`CTRL_IRQ_ID_W-1:0] irq_id_i;
  logic irq_wu_i;
  logic mtvec_vectored_i;
  logic if_valid_i;
  logic id_ready_i;

  logic instr_req_o;
  logic ctrl_busy_o;
  logic pc_set_o;
  pc_mux_e pc_mux_o;
  exc_pc_mux_e exc_pc_mux_o;
  logic [`CTRL_IRQ_ID_W-1:0] exc_vec_o;
  logic kill_if_o;
  logic kill_id_o;
  logic kill_ex_o;
  logic kill_wb_o;
  logic halt_if_o;
  logic halt_id_o;
  logic halt_wb_o;
  logic irq_ack_o;
  logic [`CTRL_IRQ_ID_W-1:0] irq_id_o;
  logic csr_save_cause_o;
  logic csr_cause_irq_o;
  logic [`CTRL_CAUSE_W-1:0] csr_cause_code_o;
  save_sel_e csr_save_sel_o;
  logic csr_restore_mret_o;
  logic pending_nmi_o;

  int mismatches;
  int other_errors;
  int checked;

  ctrl_top UUT (.*);

  // 100 ns clock
  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and comparison
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_vector(input logic [VEC_W-1:0] v);
    fetch_enable_i     = v[69];
    id_instr_valid_i   = v[68];
    id_jump_i          = v[67];
    id_mret_i          = v[66];
    id_stall_i         = v[65];
    ex_instr_valid_i   = v[64];
    ex_branch_taken_i  = v[63];
    wb_instr_valid_i   = v[62];
    wb_instr_fault_i   = v[61];
    wb_instr_bus_err_i = v[60];
    wb_illegal_i       = v[59];
    wb_ecall_i         = v[58];
    wb_ebreak_i        = v[57];
    wb_wfi_i           = v[56];
    wb_mret_i          = v[55];
    wb_lsu_i           = v[54];
    wb_rf_we_i         = v[53];
    wb_mpu_status_i    = mpu_status_e'(v[52:51]);
    lsu_err_wb_i       = v[50];
    irq_req_i          = v[49];
    irq_wu_i           = v[43];
    if_valid_i         = v[41];
    id_ready_i         = v[40];
    // Id and vector mode are random filler without a request
    if (v[49]) begin
      irq_id_i         = v[48:44];
      mtvec_vectored_i = v[42];
    end else begin
      irq_id_i         = 5'($urandom);
      mtvec_vectored_i = 1'($urandom);
    end
  endtask

  task automatic check_field(input string name, input logic [7:0] act,
                             input logic [7:0] exp);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch at %0d ns: %s expected %0h, actual %0h", $time, name, exp, act);
    end
  endtask

  task automatic check_outputs(input logic [VEC_W-1:0] v);
    check_field("instr_req_o",        8'(instr_req_o),        8'(v[39]));
    check_field("ctrl_busy_o",        8'(ctrl_busy_o),        8'(v[38]));
    check_field("pc_set_o",           8'(pc_set_o),           8'(v[37]));
    check_field("pc_mux_o",           8'(pc_mux_o),           8'(v[36:34]));
    check_field("exc_pc_mux_o",       8'(exc_pc_mux_o),       8'(v[33:32]));
    check_field("exc_vec_o",          8'(exc_vec_o),          8'(v[31:27]));
    check_field("kill_if_o",          8'(kill_if_o),          8'(v[26]));
    check_field("kill_id_o",          8'(kill_id_o),          8'(v[25]));
    check_field("kill_ex_o",          8'(kill_ex_o),          8'(v[24]));
    check_field("kill_wb_o",          8'(kill_wb_o),          8'(v[23]));
    check_field("halt_if_o",          8'(halt_if_o),          8'(v[22]));
    check_field("halt_id_o",          8'(halt_id_o),          8'(v[21]));
    check_field("halt_wb_o",          8'(halt_wb_o),          8'(v[20]));
    check_field("irq_ack_o",          8'(irq_ack_o),          8'(v[19]));
    check_field("irq_id_o",           8'(irq_id_o),           8'(v[18:14]));
    check_field("csr_save_cause_o",   8'(csr_save_cause_o),   8'(v[13]));
    check_field("csr_cause_irq_o",    8'(csr_cause_irq_o),    8'(v[12]));
    check_field("csr_cause_code_o",   csr_cause_code_o,       v[11:4]);
    check_field("csr_save_sel_o",     8'(csr_save_sel_o),     8'(v[3:2]));
    check_field("csr_restore_mret_o", 8'(csr_restore_mret_o), 8'(v[1]));
    check_field("pending_nmi_o",      8'(pending_nmi_o),      8'(v[0]));
  endtask

  // Falling-edge aligned wait for the core to go to sleep
  task automatic wait_for_sleep();
    int cycles;
    cycles = 0;
    while (ctrl_busy_o !== 1'b0 && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (ctrl_busy_o !== 1'b0) begin
      other_errors++;
      $display("Core did not enter sleep within %0d cycles at %0d ns", WAIT_LIMIT, $time);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int  fd;
    bit  file_ok;
    bit  found_end;
    void'($urandom(32'h118e6b0d));
    mismatches   = 0;
    other_errors = 0;
    checked      = 0;
    found_end    = 1'b0;
    clk          = 1'b0;
    rst_n        = 1'b0;
    drive_vector('0);

    fd = $fopen("verif/ctrl_tests.txt", "r");
    file_ok = (fd != 0);
    if (file_ok) begin
      $fclose(fd);
      $readmemb("verif/ctrl_tests.txt", vec_mem);
    end else begin
      other_errors++;
      $display("Could not open the vector file verif/ctrl_tests.txt");
    end

    // Reset held for 10 cycles and released on a falling edge
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    if (file_ok) begin
      for (int i = 0; i < MAX_VEC && !found_end; i++) begin
        vec = vec_mem[i];
        if (vec === {VEC_W{1'b1}}) begin
          found_end = 1'b1;
        end else begin
          @(negedge clk);
          if (vec[70]) begin
            wait_for_sleep();
          end
          drive_vector(vec);
          // Sample just before the next rising edge
          #40;
          check_outputs(vec);
          checked++;
        end
      end
      if (!found_end) begin
        other_errors++;
        $display("Vector file has no end marker line");
      end
    end

    $display("Vectors checked: %0d, mismatches: %0d, other errors: %0d",
             checked, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/ctrl_tests.txt
// Inputs: wait_fe_id[v,jmp,mret,stall]_ex[v,br]_wb[v,ifault,buserr,ill,ecall,ebreak,wfi,mret,lsu,we]
//   _mpu_[lsuerr,irq]_irqid_[wu,vect,ifvalid,idready]
// Expected: [req,busy,pcset]_pcmux_excmux_excvec_kills[if,id,ex,wb]_halts[if,id,wb]_ack_irqid
//   _[save,irq]_code_sel_[restore,pendnmi]; all-ones line ends the list
// Reset and boot
0_0_0000_00_0000000000_00_00_00000_0000_010_000_00_00000_0000_000_0_00000_00_00000000_00_00
0_1_0000_00_0000000000_00_00_00000_0011_010_000_00_00000_0000_000_0_00000_00_00000000_00_00
0_1_0000_00_0000000000_00_00_00000_0011_111_000_00_00000_0000_000_0_00000_00_00000000_00_00
0_1_0000_00_0000000000_00_00_00000_0011_110_000_00_00000_0000_000_0_00000_00_00000000_00_00
// Exception cause priority
0_1_0000_00_1001010000_10_00_00000_0011_111_100_00_00000_1110_000_0_00000_10_00000010_11_00
0_1_0000_00_1010100000_00_00_00000_0011_111_100_00_00000_1110_000_0_00000_10_00000001_11_00
0_1_0000_00_1000110000_00_00_00000_0011_111_100_00_00000_1110_000_0_00000_10_00001011_11_00
0_1_0000_00_1000000000_01_00_00000_0011_111_100_00_00000_1110_000_0_00000_10_00000101_11_00
0_1_0000_00_1000000000_10_00_00000_0011_111_100_00_00000_1110_000_0_00000_10_00000111_11_00
0_1_0000_00_1101000000_00_00_00000_0011_111_100_00_00000_1110_000_0_00000_10_00000001_11_00
0_1_0000_00_0001000000_00_00_00000_0011_110_000_00_00000_0000_000_0_00000_00_00000000_00_00
// Interrupts, held off by a load/store in WB
0_1_0000_00_1000000010_00_01_00101_0111_110_000_00_00000_0000_010_0_00000_00_00000000_00_00
0_1_1000_10_0000000000_00_01_00101_0111_111_100_01_00101_1111_000_1_00101_11_00000101_10_00
0_1_1000_00_0000000000_00_01_01001_0011_111_100_01_00000_1111_000_1_01001_11_00001001_01_00
0_1_0000_00_0000000000_00_01_00011_0111_111_100_01_00011_1111_000_1_00011_11_00000011_00_00
0_1_0000_00_1000000100_00_01_00010_0011_111_100_01_00000_1111_000_1_00010_11_00000010_11_00
0_1_0000_00_1000000100_00_00_00000_0011_110_000_00_00000_0000_000_0_00000_00_00000000_00_10
// NMI from a store, beats an interrupt
0_1_0000_00_1000000010_00_10_00000_0011_110_000_00_00000_0000_000_0_00000_00_00000000_00_00
0_1_0000_00_0000000000_00_01_00100_0111_111_100_10_00000_1111_000_0_00000_11_10000001_00_01
0_1_0000_00_0000000000_00_00_00000_0011_110_000_00_00000_0000_000_0_00000_00_00000000_00_00
// NMI from a load, held while WB is busy
0_1_0000_00_1000000011_00_10_00000_0011_110_000_00_00000_0000_000_0_00000_00_00000000_00_00
0_1_0000_00_1000000010_00_00_00000_0011_110_000_00_00000_0000_010_0_00000_00_00000000_00_01
0_1_0000_00_0000000000_00_00_00000_0011_111_100_10_00000_1111_000_0_00000_11_10000000_00_01
0_1_0000_00_0000000000_00_00_00000_0011_110_000_00_00000_0000_000_0_00000_00_00000000_00_00
// WFI sleep and wake-up
0_1_0000_00_1000001000_00_00_00000_0011_010_000_00_00000_0000_110_0_00000_00_00000000_00_00
1_1_0000_00_0000000000_00_00_00000_0011_000_000_00_00000_0000_001_0_00000_00_00000000_00_00
0_1_0000_00_0000000000_00_00_00000_0011_000_000_00_00000_0000_001_0_00000_00_00000000_00_00
0_1_0000_00_0000000000_00_00_00000_1011_010_000_00_00000_0000_001_0_00000_00_00000000_00_00
0_1_0000_00_0000000000_00_00_00000_0011_110_000_00_00000_0000_000_0_00000_00_00000000_00_00
// Held branch, jump and mret taken once
0_1_0001_11_0000000000_00_00_00000_0000_111_010_00_00000_1100_010_0_00000_00_00000000_00_00
0_1_0001_11_0000000000_00_00_00000_0000_110_000_00_00000_0000_010_0_00000_00_00000000_00_00
0_1_0001_11_0000000000_00_00_00000_0000_110_000_00_00000_0000_010_0_00000_00_00000000_00_00
0_1_0000_00_0000000000_00_00_00000_0011_110_000_00_00000_0000_000_0_00000_00_00000000_00_00
0_1_1101_00_0000000000_00_00_00000_0000_110_000_00_00000_0000_010_0_00000_00_00000000_00_00
0_1_1100_00_0000000000_00_00_00000_0000_111_001_00_00000_1000_000_0_00000_00_00000000_00_00
0_1_1100_00_0000000000_00_00_00000_0000_110_000_00_00000_0000_000_0_00000_00_00000000_00_00
0_1_0000_00_0000000000_00_00_00000_0011_110_000_00_00000_0000_000_0_00000_00_00000000_00_00
0_1_1010_00_0000000000_00_00_00000_0000_111_011_00_00000_1000_000_0_00000_00_00000000_00_00
0_1_0000_00_0000000000_00_00_00000_0011_110_000_00_00000_0000_000_0_00000_00_00000000_00_00
1_1_1111_11_1111111111_11_11_11111_1111_111_111_11_11111_1111_111_1_11111_11_11111111_11_11

//--- verilog.f
+incdir+design
design/ctrl_pkg.sv
design/wb_event_if.sv
design/wb_event_decode.sv
design/trap_pending.sv
design/ctrl_fsm.sv
design/ctrl_top.sv
verif/ctrl_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module ctrl_tb -o ctrl_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output="$(./obj_dir/ctrl_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
